// ==== common/stk_pkg.sv ====
// Stack unit shared definitions
// Opcode encoding, the stack data word and the fixed-width bundles that
// move between the pipeline stages. Widths that follow the engine count or
// the entry count are sized inside each module instead.

package stk_pkg;

  // Command opcode presented by each engine as a level
  typedef logic [1:0] opcode_t;

  // Idle engine, nothing to admit
  localparam opcode_t OP_NOP  = 2'd0;

  // Place the data word on top of the engine's stack
  localparam opcode_t OP_PUSH = 2'd1;

  // Remove the top entry and return its data word
  localparam opcode_t OP_POP  = 2'd2;

  // Width of one stack data word
  localparam int DAT_W = 128;

  typedef logic [DAT_W-1:0] dat_t;

  // Result of a completed operation, strobed back to the engine.
  // The data word is zero unless a pop succeeded
  typedef struct packed {
    logic err;
    dat_t dat;
  } rsp_t;

  // Admitted command as it travels from admission towards writeback.
  // The engine id and the entry pointer are carried next to it
  typedef struct packed {
    opcode_t opcode;
    dat_t    dat;
  } lk_cmd_t;

endpackage : stk_pkg

// ==== stk_pipe/stk_pipe_ad.sv ====
// Stack unit admission stage
// Picks one engine per cycle with a round-robin pointer, acknowledges it
// and forwards its command towards lookup. Keeps one in-flight bit per
// engine so that each engine has at most one operation in the pipeline.

`timescale 1ns/100ps

module stk_pipe_ad #(
  parameter int ENGS_N = 4
, localparam int ENGID_W = (ENGS_N > 1) ? $clog2(ENGS_N) : 1
) (
  input wire stk_pkg::opcode_t [ENGS_N-1:0] i_cmd_opcode
, input wire stk_pkg::dat_t [ENGS_N-1:0]    i_cmd_dat
, output logic [ENGS_N-1:0]                 o_cmd_ack
, output logic                              o_lk_vld_w
, output logic [ENGID_W-1:0]                o_lk_engid_w
, output stk_pkg::lk_cmd_t                  o_lk_cmd_w
, input wire logic                          i_al_empty_r
, input wire logic                          i_al_busy_r
, output logic                              o_al_alloc
, input wire logic [ENGS_N-1:0]             i_rsp_vld
, input wire logic                          clk
, input wire logic                          i_arst_n
);

  typedef logic [ENGID_W-1:0] engid_t;

  logic [ENGS_N-1:0] inflight_r;
  logic [ENGS_N-1:0] eligible;
  engid_t            rr_r;
  engid_t            sel;
  logic              sel_vld;

  // An engine competes when it presents work and has nothing in flight
  always_comb begin
    for (int e = 0; e < ENGS_N; e++) begin
      eligible[e] = (i_cmd_opcode[e] != stk_pkg::OP_NOP) && !inflight_r[e];
    end
  end

  // Scan from the round-robin pointer and take the first eligible engine
  always_comb begin
    int unsigned idx;
    sel     = rr_r;
    sel_vld = 1'b0;
    for (int i = 0; i < ENGS_N; i++) begin
      idx = int'(rr_r) + i;
      // Wrap without a modulo so that any engine count works
      if (idx >= ENGS_N)
        idx = idx - ENGS_N;
      if (!sel_vld && eligible[idx]) begin
        sel     = engid_t'(idx);
        sel_vld = 1'b1;
      end
    end
  end

  // Nothing is admitted while the allocator still builds its free list
  assign o_lk_vld_w   = sel_vld && !i_al_busy_r;
  assign o_cmd_ack    = o_lk_vld_w ? (ENGS_N'(1) << sel) : '0;
  assign o_lk_engid_w = sel;

  assign o_lk_cmd_w.opcode = i_cmd_opcode[sel];
  assign o_lk_cmd_w.dat    = i_cmd_dat[sel];

  // A push only takes a pointer when one is there; otherwise lookup sees
  // no grant and reports the error
  assign o_al_alloc = o_lk_vld_w && (i_cmd_opcode[sel] == stk_pkg::OP_PUSH)
                      && !i_al_empty_r;

  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      inflight_r <= '0;
      rr_r       <= '0;
    end else begin
      // Ack and response never hit the same engine in one cycle
      inflight_r <= (inflight_r | o_cmd_ack) & ~i_rsp_vld;
      if (o_lk_vld_w)
        rr_r <= (sel == engid_t'(ENGS_N - 1)) ? '0 : sel + 1'b1;
    end
  end

  // Writeback answers one engine at a time, and only one that is in flight
  a_rsp_inflight : assert property (@(posedge clk) disable iff (!i_arst_n)
    $onehot0(i_rsp_vld) && ((i_rsp_vld & ~inflight_r) == '0));

  // The allocator's initialization walk runs once, right after reset
  a_busy_once : assert property (@(posedge clk) disable iff (!i_arst_n)
    !i_al_busy_r |=> !i_al_busy_r);

endmodule : stk_pipe_ad

// ==== stk_pipe/stk_pipe_al.sv ====
// Stack unit allocation stage
// Circular free list of entry pointers shared by all engine stacks.
// After reset it writes every pointer into the list, one per cycle, and
// reports busy while doing so. A granted pointer is registered together
// with a grant flag so that it lines up with the command in lookup.

`timescale 1ns/100ps

module stk_pipe_al #(
  parameter int ENTRIES_N = 8
, localparam int PTR_W = $clog2(ENTRIES_N)
) (
  input wire logic               i_ad_alloc
, output logic                   o_ad_empty_r
, output logic                   o_ad_busy_r
, output logic [PTR_W:0]         o_lk_ptr
, input wire logic               i_dealloc_vld
, input wire logic [PTR_W-1:0]   i_dealloc_ptr
, input wire logic               clk
, input wire logic               i_arst_n
);

  typedef logic [PTR_W-1:0] ptr_t;
  typedef logic [PTR_W:0]   cnt_t;

  typedef enum logic {
    ST_INIT,
    ST_RUN
  } state_t;

  state_t state_r;
  ptr_t   fl_mem [ENTRIES_N];
  ptr_t   rd_idx_r;
  ptr_t   wr_idx_r;
  cnt_t   cnt_r;
  ptr_t   ptr_r;
  logic   ptr_vld_r;
  logic   fl_push;
  ptr_t   fl_push_ptr;

  // During the walk the write index doubles as the pointer being freed
  assign fl_push     = (state_r == ST_INIT) || i_dealloc_vld;
  assign fl_push_ptr = (state_r == ST_INIT) ? wr_idx_r : i_dealloc_ptr;

  assign o_ad_busy_r  = (state_r == ST_INIT);
  assign o_ad_empty_r = (cnt_r == '0);

  // Grant flag in the top bit, pointer below it
  assign o_lk_ptr = {ptr_vld_r, ptr_r};

  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      state_r   <= ST_INIT;
      rd_idx_r  <= '0;
      wr_idx_r  <= '0;
      cnt_r     <= '0;
      ptr_vld_r <= 1'b0;
    end else begin
      // The walk ends after the last pointer, which keeps busy high for
      // exactly one cycle per entry
      if ((state_r == ST_INIT) && (wr_idx_r == ptr_t'(ENTRIES_N - 1)))
        state_r <= ST_RUN;
      if (fl_push)
        wr_idx_r <= wr_idx_r + 1'b1;
      if (i_ad_alloc)
        rd_idx_r <= rd_idx_r + 1'b1;
      // A free and a grant in the same cycle cancel in the count
      cnt_r     <= cnt_r + cnt_t'(fl_push) - cnt_t'(i_ad_alloc);
      ptr_vld_r <= i_ad_alloc;
    end
  end

  always_ff @(posedge clk) begin
    if (fl_push)
      fl_mem[wr_idx_r] <= fl_push_ptr;
    if (i_ad_alloc)
      ptr_r <= fl_mem[rd_idx_r];
  end

  // Admission only asks for a pointer when one is free and the walk is over
  a_alloc_legal : assert property (@(posedge clk) disable iff (!i_arst_n)
    i_ad_alloc |-> ((cnt_r != '0) && (state_r == ST_RUN)));

  // Writeback never returns more pointers than the list can hold
  a_dealloc_legal : assert property (@(posedge clk) disable iff (!i_arst_n)
    (i_dealloc_vld && !i_ad_alloc) |-> ((cnt_r < cnt_t'(ENTRIES_N))
                                        && (state_r == ST_RUN)));

endmodule : stk_pipe_al

// ==== stk_pipe/stk_pipe_lk.sv ====
// Stack unit lookup stage
// Keeps the head pointer and depth of every engine's stack and decides
// whether each admitted operation succeeds. A push moves the head to the
// granted pointer at once; a pop lowers the depth here and receives its
// new head later from writeback.

`timescale 1ns/100ps

module stk_pipe_lk #(
  parameter int ENGS_N = 4
, parameter int ENTRIES_N = 8
, localparam int ENGID_W = (ENGS_N > 1) ? $clog2(ENGS_N) : 1
, localparam int PTR_W = $clog2(ENTRIES_N)
) (
  input wire logic                 i_lk_vld_r
, input wire logic [ENGID_W-1:0]   i_lk_engid_r
, input wire stk_pkg::lk_cmd_t     i_lk_cmd_r
, input wire logic [PTR_W:0]       i_lk_ptr
, input wire logic                 i_hd_vld
, input wire logic [ENGID_W-1:0]   i_hd_engid
, input wire logic [PTR_W-1:0]     i_hd_ptr
, output logic                     o_wb_vld
, output logic [ENGID_W-1:0]       o_wb_engid
, output stk_pkg::lk_cmd_t         o_wb_cmd
, output logic [PTR_W-1:0]         o_wb_ptr
, output logic [PTR_W-1:0]         o_wb_link
, output logic                     o_wb_err
, input wire logic                 clk
, input wire logic                 i_arst_n
);

  typedef logic [PTR_W-1:0] ptr_t;
  typedef logic [PTR_W:0]   depth_t;

  ptr_t        head_r [ENGS_N];
  depth_t      depth_r [ENGS_N];
  ptr_t        cur_head;
  depth_t      cur_depth;
  logic        push_ok;
  logic        pop_ok;
  int unsigned depth_sum;

  assign cur_head  = head_r[i_lk_engid_r];
  assign cur_depth = depth_r[i_lk_engid_r];

  // The top bit of the allocator's pointer says whether a pointer was granted
  assign push_ok = i_lk_vld_r && (i_lk_cmd_r.opcode == stk_pkg::OP_PUSH)
                   && i_lk_ptr[PTR_W];
  assign pop_ok  = i_lk_vld_r && (i_lk_cmd_r.opcode == stk_pkg::OP_POP)
                   && (cur_depth != '0);

  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      for (int e = 0; e < ENGS_N; e++) begin
        head_r[e]  <= '0;
        depth_r[e] <= '0;
      end
    end else begin
      for (int e = 0; e < ENGS_N; e++) begin
        // Head after a pop, one engine's update never meets its own next op
        if (i_hd_vld && (i_hd_engid == ENGID_W'(e)))
          head_r[e] <= i_hd_ptr;
        if (i_lk_engid_r == ENGID_W'(e)) begin
          if (push_ok) begin
            head_r[e]  <= i_lk_ptr[PTR_W-1:0];
            depth_r[e] <= depth_r[e] + 1'b1;
          end
          if (pop_ok)
            depth_r[e] <= depth_r[e] - 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n)
      o_wb_vld <= 1'b0;
    else
      o_wb_vld <= i_lk_vld_r;
  end

  always_ff @(posedge clk) begin
    if (i_lk_vld_r) begin
      o_wb_engid <= i_lk_engid_r;
      o_wb_cmd   <= i_lk_cmd_r;
      // A push writes its new entry, a pop reads the current top
      o_wb_ptr   <= push_ok ? i_lk_ptr[PTR_W-1:0] : cur_head;
      // The old head becomes the new entry's next pointer
      o_wb_link  <= cur_head;
      // Anything that neither pushes nor pops is reported as a failure
      o_wb_err   <= !(push_ok || pop_ok);
    end
  end

  always_comb begin
    depth_sum = 0;
    for (int e = 0; e < ENGS_N; e++) begin
      depth_sum = depth_sum + int'(depth_r[e]);
    end
  end

  // All stacks share one entry memory, so their depths together stay in it
  a_depth_bound : assert property (@(posedge clk) disable iff (!i_arst_n)
    depth_sum <= ENTRIES_N);

endmodule : stk_pipe_lk

// ==== stk_pipe/stk_pipe_wb.sv ====
// Stack unit writeback stage
// Holds the shared entry memory, each entry a data word and a next pointer.
// A push stores its word and link, a pop reads the top entry, hands its
// pointer back to the allocator and its next pointer back to lookup.
// The response to the engine is registered here.

`timescale 1ns/100ps

module stk_pipe_wb #(
  parameter int ENGS_N = 4
, parameter int ENTRIES_N = 8
, localparam int ENGID_W = (ENGS_N > 1) ? $clog2(ENGS_N) : 1
, localparam int PTR_W = $clog2(ENTRIES_N)
) (
  input wire logic                 i_wb_vld
, input wire logic [ENGID_W-1:0]   i_wb_engid
, input wire stk_pkg::lk_cmd_t     i_wb_cmd
, input wire logic [PTR_W-1:0]     i_wb_ptr
, input wire logic [PTR_W-1:0]     i_wb_link
, input wire logic                 i_wb_err
, output logic                     o_hd_vld
, output logic [ENGID_W-1:0]       o_hd_engid
, output logic [PTR_W-1:0]         o_hd_ptr
, output logic                     o_dealloc_vld
, output logic [PTR_W-1:0]         o_dealloc_ptr
, output logic [ENGS_N-1:0]        o_rsp_vld
, output stk_pkg::rsp_t            o_rsp
, input wire logic                 clk
, input wire logic                 i_arst_n
);

  typedef logic [PTR_W-1:0] ptr_t;

  stk_pkg::dat_t mem_dat [ENTRIES_N];
  ptr_t          mem_nxt [ENTRIES_N];
  logic          push_ok;
  logic          pop_ok;
  stk_pkg::dat_t rd_dat;
  ptr_t          rd_nxt;

  // Failed operations leave the memory untouched
  assign push_ok = i_wb_vld && !i_wb_err && (i_wb_cmd.opcode == stk_pkg::OP_PUSH);
  assign pop_ok  = i_wb_vld && !i_wb_err && (i_wb_cmd.opcode == stk_pkg::OP_POP);

  // Only one operation is in this stage per cycle, so read and write never
  // meet on the same entry
  assign rd_dat = mem_dat[i_wb_ptr];
  assign rd_nxt = mem_nxt[i_wb_ptr];

  always_ff @(posedge clk) begin
    if (push_ok) begin
      mem_dat[i_wb_ptr] <= i_wb_cmd.dat;
      mem_nxt[i_wb_ptr] <= i_wb_link;
    end
  end

  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      o_hd_vld      <= 1'b0;
      o_dealloc_vld <= 1'b0;
      o_rsp_vld     <= '0;
    end else begin
      o_hd_vld      <= pop_ok;
      o_dealloc_vld <= pop_ok;
      // One-hot strobe towards the engine that issued the operation
      o_rsp_vld     <= i_wb_vld ? (ENGS_N'(1) << i_wb_engid) : '0;
    end
  end

  // New head and the freed pointer both come from the popped entry
  always_ff @(posedge clk) begin
    if (pop_ok) begin
      o_hd_engid    <= i_wb_engid;
      o_hd_ptr      <= rd_nxt;
      o_dealloc_ptr <= i_wb_ptr;
    end
  end

  always_ff @(posedge clk) begin
    if (i_wb_vld) begin
      o_rsp.err <= i_wb_err;
      // Data is returned by a successful pop only
      o_rsp.dat <= pop_ok ? rd_dat : '0;
    end
  end

endmodule : stk_pipe_wb

// ==== stk_pipe/stk_pipe.sv ====
// Stack unit top level
// Per-engine LIFO stacks kept as linked lists in one shared entry memory.
// Four stages: admission, allocation, lookup and writeback. A command
// acknowledged in one cycle has its response three cycles later.

`timescale 1ns/100ps

module stk_pipe #(
  parameter int ENGS_N = 4
, parameter int ENTRIES_N = 8
) (
  input wire stk_pkg::opcode_t [ENGS_N-1:0] i_cmd_opcode
, input wire stk_pkg::dat_t [ENGS_N-1:0]    i_cmd_dat
, output logic [ENGS_N-1:0]                 o_cmd_ack
, output logic [ENGS_N-1:0]                 o_rsp_vld
, output stk_pkg::rsp_t                     o_rsp
, input wire logic                          clk
, input wire logic                          i_arst_n
);

  localparam int ENGID_W = (ENGS_N > 1) ? $clog2(ENGS_N) : 1;
  localparam int PTR_W   = $clog2(ENTRIES_N);

  // Admission and allocation handshake
  logic                 al_ad_empty_r;
  logic                 al_ad_busy_r;
  logic                 ad_al_alloc;

  // Admission to lookup, before and after the stage register
  logic                 lk_vld_w;
  logic [ENGID_W-1:0]   lk_engid_w;
  stk_pkg::lk_cmd_t     lk_cmd_w;
  logic                 lk_vld_r;
  logic [ENGID_W-1:0]   lk_engid_r;
  stk_pkg::lk_cmd_t     lk_cmd_r;

  // Granted pointer with its grant flag on top
  logic [PTR_W:0]       al_lk_ptr;

  // Lookup to writeback
  logic                 wb_vld;
  logic [ENGID_W-1:0]   wb_engid;
  stk_pkg::lk_cmd_t     wb_cmd;
  logic [PTR_W-1:0]     wb_ptr;
  logic [PTR_W-1:0]     wb_link;
  logic                 wb_err;

  // Writeback back to lookup and allocation
  logic                 hd_vld;
  logic [ENGID_W-1:0]   hd_engid;
  logic [PTR_W-1:0]     hd_ptr;
  logic                 dealloc_vld;
  logic [PTR_W-1:0]     dealloc_ptr;

  stk_pipe_ad #(.ENGS_N(ENGS_N)) u_stk_pipe_ad (
    .i_cmd_opcode   (i_cmd_opcode)
  , .i_cmd_dat      (i_cmd_dat)
  , .o_cmd_ack      (o_cmd_ack)
  , .o_lk_vld_w     (lk_vld_w)
  , .o_lk_engid_w   (lk_engid_w)
  , .o_lk_cmd_w     (lk_cmd_w)
  , .i_al_empty_r   (al_ad_empty_r)
  , .i_al_busy_r    (al_ad_busy_r)
  , .o_al_alloc     (ad_al_alloc)
  , .i_rsp_vld      (o_rsp_vld)
  , .clk            (clk)
  , .i_arst_n       (i_arst_n)
  );

  // Only the valid bit is reset, the command is loaded when valid
  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n)
      lk_vld_r <= 1'b0;
    else
      lk_vld_r <= lk_vld_w;
  end

  always_ff @(posedge clk) begin
    if (lk_vld_w) begin
      lk_engid_r <= lk_engid_w;
      lk_cmd_r   <= lk_cmd_w;
    end
  end

  stk_pipe_al #(.ENTRIES_N(ENTRIES_N)) u_stk_pipe_al (
    .i_ad_alloc     (ad_al_alloc)
  , .o_ad_empty_r   (al_ad_empty_r)
  , .o_ad_busy_r    (al_ad_busy_r)
  , .o_lk_ptr       (al_lk_ptr)
  , .i_dealloc_vld  (dealloc_vld)
  , .i_dealloc_ptr  (dealloc_ptr)
  , .clk            (clk)
  , .i_arst_n       (i_arst_n)
  );

  stk_pipe_lk #(.ENGS_N(ENGS_N), .ENTRIES_N(ENTRIES_N)) u_stk_pipe_lk (
    .i_lk_vld_r     (lk_vld_r)
  , .i_lk_engid_r   (lk_engid_r)
  , .i_lk_cmd_r     (lk_cmd_r)
  , .i_lk_ptr       (al_lk_ptr)
  , .i_hd_vld       (hd_vld)
  , .i_hd_engid     (hd_engid)
  , .i_hd_ptr       (hd_ptr)
  , .o_wb_vld       (wb_vld)
  , .o_wb_engid     (wb_engid)
  , .o_wb_cmd       (wb_cmd)
  , .o_wb_ptr       (wb_ptr)
  , .o_wb_link      (wb_link)
  , .o_wb_err       (wb_err)
  , .clk            (clk)
  , .i_arst_n       (i_arst_n)
  );

  stk_pipe_wb #(.ENGS_N(ENGS_N), .ENTRIES_N(ENTRIES_N)) u_stk_pipe_wb (
    .i_wb_vld       (wb_vld)
  , .i_wb_engid     (wb_engid)
  , .i_wb_cmd       (wb_cmd)
  , .i_wb_ptr       (wb_ptr)
  , .i_wb_link      (wb_link)
  , .i_wb_err       (wb_err)
  , .o_hd_vld       (hd_vld)
  , .o_hd_engid     (hd_engid)
  , .o_hd_ptr       (hd_ptr)
  , .o_dealloc_vld  (dealloc_vld)
  , .o_dealloc_ptr  (dealloc_ptr)
  , .o_rsp_vld      (o_rsp_vld)
  , .o_rsp          (o_rsp)
  , .clk            (clk)
  , .i_arst_n       (i_arst_n)
  );

  // Every acknowledge comes back as that engine's response three cycles on
  for (genvar e = 0; e < ENGS_N; e++) begin : g_rsp_chk
    a_ack_to_rsp : assert property (@(posedge clk) disable iff (!i_arst_n)
      o_cmd_ack[e] |-> ##3 o_rsp_vld[e]);
  end

endmodule : stk_pipe

// ==== verif/stk_pipe_clk_gen.sv ====
// Stack unit testbench clock and reset
// Free-running 10 ns clock. Reset is held low for the first eight clock
// periods and released on a falling edge.

`timescale 1ns/100ps

module stk_pipe_clk_gen #(
  parameter int RST_CYC = 8
) (
  output logic o_clk
, output logic o_arst_n
);

  initial begin
    o_clk = 1'b0;
    forever #5 o_clk = ~o_clk;
  end

  // Release away from the rising edge so that no flop sees it change
  initial begin
    o_arst_n = 1'b0;
    repeat (RST_CYC) @(posedge o_clk);
    @(negedge o_clk);
    o_arst_n = 1'b1;
  end

endmodule : stk_pipe_clk_gen

// ==== verif/stk_pipe_tb.sv ====
// Stack unit testbench
// Four engines issue random pushes and pops against eight shared entries.
// Traffic alternates between push-heavy and pop-heavy phases so that the
// entry memory fills up and the stacks run empty. A reference model of the
// per-engine stacks predicts every response, and concurrent assertions
// compare the DUT against it.

`timescale 1ns/100ps

module stk_pipe_tb;

  localparam int ENGS_N    = 4;
  localparam int ENTRIES_N = 8;
  // Acks after which every engine goes idle
  localparam int ACKS_N    = 240;
  // Phase length in acks
  localparam int PHASE_N   = 20;
  localparam int RST_TMO   = 50;
  localparam int RUN_TMO   = 20000;
  localparam int DRAIN_TMO = 100;

  logic clk;
  logic arst_n;

  stk_pkg::opcode_t [ENGS_N-1:0] cmd_opcode;
  stk_pkg::dat_t [ENGS_N-1:0]    cmd_dat;
  logic [ENGS_N-1:0]             cmd_ack;
  logic [ENGS_N-1:0]             rsp_vld;
  stk_pkg::rsp_t                 rsp;

  integer seed = 32'h3b9b;
  int     err_cnt = 0;
  int     ack_cnt = 0;
  int     rsp_cnt = 0;
  int     sent_cnt = 0;
  int     used_cnt = 0;
  int     rst_cyc = 0;
  int     push_full_cnt = 0;
  int     push_reuse_cnt = 0;
  int     pop_ok_cnt = 0;
  int     pop_empty_cnt = 0;

  // Reference stacks, newest word at the back
  stk_pkg::dat_t stack_q [ENGS_N][$];
  // Expected response of each engine's operation in flight
  stk_pkg::rsp_t exp_rsp [ENGS_N];
  // Successful pops acked in each of the last four cycles, newest in bit 0
  logic [3:0]    free_sr = '0;

  stk_pipe_clk_gen #(.RST_CYC(8)) u_clk_gen (
    .o_clk    (clk)
  , .o_arst_n (arst_n)
  );

  stk_pipe #(.ENGS_N(ENGS_N), .ENTRIES_N(ENTRIES_N)) stk_pipe_inst (
    .i_cmd_opcode (cmd_opcode)
  , .i_cmd_dat    (cmd_dat)
  , .o_cmd_ack    (cmd_ack)
  , .o_rsp_vld    (rsp_vld)
  , .o_rsp        (rsp)
  , .clk          (clk)
  , .i_arst_n     (arst_n)
  );

  // Push-heavy phases fill the shared memory, pop-heavy ones drain it
  function automatic stk_pkg::opcode_t pick_opcode(input int n);
    logic [31:0] r;
    logic        fill;
    r    = $random(seed);
    fill = ((n / PHASE_N) % 2) == 0;
    if (fill)
      return (r[1:0] != 2'd0) ? stk_pkg::OP_PUSH : stk_pkg::OP_POP;
    else
      return (r[1:0] == 2'd0) ? stk_pkg::OP_PUSH : stk_pkg::OP_POP;
  endfunction

  function automatic stk_pkg::dat_t rand_word();
    stk_pkg::dat_t w;
    for (int i = 0; i < stk_pkg::DAT_W / 32; i++)
      w[i*32 +: 32] = $random(seed);
    return w;
  endfunction

  // Applies one acknowledged command to the reference stacks
  task automatic predict_rsp(input int e, output logic freed);
    freed = 1'b0;
    ack_cnt++;
    exp_rsp[e].err = 1'b0;
    exp_rsp[e].dat = '0;
    if (cmd_opcode[e] == stk_pkg::OP_PUSH) begin
      if (used_cnt == ENTRIES_N) begin
        exp_rsp[e].err = 1'b1;
        push_full_cnt++;
      end else begin
        stack_q[e].push_back(cmd_dat[e]);
        used_cnt++;
        if (push_full_cnt > 0)
          push_reuse_cnt++;
      end
    end else if (stack_q[e].size() == 0) begin
      exp_rsp[e].err = 1'b1;
      pop_empty_cnt++;
    end else begin
      exp_rsp[e].dat = stack_q[e].pop_back();
      freed = 1'b1;
      pop_ok_cnt++;
    end
  endtask

  // Cycles since reset release, saturating once the first ack is due
  always @(posedge clk or negedge arst_n) begin
    if (!arst_n)
      rst_cyc <= 0;
    else if (rst_cyc <= ENTRIES_N)
      rst_cyc <= rst_cyc + 1;
  end

  // A popped entry is freed with the response and can be granted again
  // to a push acknowledged four cycles after the pop
  always @(posedge clk) begin
    logic freed;
    logic any_freed;
    if (arst_n) begin
      any_freed = 1'b0;
      if (free_sr[3])
        used_cnt--;
      for (int e = 0; e < ENGS_N; e++) begin
        if (cmd_ack[e]) begin
          predict_rsp(e, freed);
          any_freed = any_freed | freed;
        end
      end
      free_sr = {free_sr[2:0], any_freed};
      if (rsp_vld != '0)
        rsp_cnt++;
    end
  end

  // Each engine holds its command until acked, then issues the next
  always @(posedge clk) begin
    for (int e = 0; e < ENGS_N; e++) begin
      if (arst_n && cmd_ack[e]) begin
        sent_cnt = sent_cnt + 1;
        if (sent_cnt >= ACKS_N) begin
          cmd_opcode[e] <= stk_pkg::OP_NOP;
        end else begin
          cmd_opcode[e] <= pick_opcode(sent_cnt);
          cmd_dat[e]    <= rand_word();
        end
      end
    end
  end

  a_quiet_init : assert property (@(posedge clk) disable iff (!arst_n)
    (rst_cyc < ENTRIES_N) |-> ((cmd_ack == '0) && (rsp_vld == '0)))
    else begin
      err_cnt++;
      $display("FAIL %0t: ack or response during free-list initialization", $time);
    end

  a_first_ack : assert property (@(posedge clk) disable iff (!arst_n)
    (rst_cyc == ENTRIES_N) |-> (cmd_ack != '0))
    else begin
      err_cnt++;
      $display("FAIL %0t: no ack right after initialization", $time);
    end

  for (genvar e = 0; e < ENGS_N; e++) begin : g_eng_chk
    // The response for an ack comes three cycles later and for e alone
    a_rsp_timing : assert property (@(posedge clk) disable iff (!arst_n)
      $past(cmd_ack[e], 3) |-> (rsp_vld == (ENGS_N'(1) << e)))
      else begin
        err_cnt++;
        $display("FAIL %0t: engine %0d response strobe %b three cycles after ack",
                 $time, e, $sampled(rsp_vld));
      end

    a_rsp_orphan : assert property (@(posedge clk) disable iff (!arst_n)
      rsp_vld[e] |-> ($past(cmd_ack[e], 3) && !$past(cmd_ack[e], 1)
                      && !$past(cmd_ack[e], 2)))
      else begin
        err_cnt++;
        $display("FAIL %0t: engine %0d response not three cycles after its ack",
                 $time, e);
      end

    a_rsp_value : assert property (@(posedge clk) disable iff (!arst_n)
      rsp_vld[e] |-> (rsp == exp_rsp[e]))
      else begin
        err_cnt++;
        $display("FAIL %0t: engine %0d got err %0b data %h", $time, e,
                 $sampled(rsp.err), $sampled(rsp.dat));
        $display("FAIL %0t: engine %0d expected err %0b data %h", $time, e,
                 exp_rsp[e].err, exp_rsp[e].dat);
      end
  end

  initial begin
    int   waited;
    logic timed_out;
    timed_out = 1'b0;
    for (int e = 0; e < ENGS_N; e++) begin
      cmd_opcode[e] = pick_opcode(0);
      cmd_dat[e]    = rand_word();
    end
    waited = 0;
    while ((arst_n !== 1'b1) && (waited < RST_TMO)) begin
      @(negedge clk);
      waited++;
    end
    if (arst_n !== 1'b1) begin
      timed_out = 1'b1;
      $display("Timeout: reset was not released within %0d cycles", RST_TMO);
    end
    waited = 0;
    while (!timed_out && (sent_cnt < ACKS_N) && (waited < RUN_TMO)) begin
      @(negedge clk);
      waited++;
    end
    if (!timed_out && (sent_cnt < ACKS_N)) begin
      timed_out = 1'b1;
      $display("Timeout: only %0d of %0d commands were acked", sent_cnt, ACKS_N);
    end
    // Let the other engines finish their last commands and the pipe drain
    waited = 0;
    while (!timed_out && ((cmd_opcode != '0) || (rsp_cnt != ack_cnt))
           && (waited < DRAIN_TMO)) begin
      @(negedge clk);
      waited++;
    end
    if (!timed_out && ((cmd_opcode != '0) || (rsp_cnt != ack_cnt))) begin
      timed_out = 1'b1;
      $display("Timeout: %0d acks but %0d responses after the last command",
               ack_cnt, rsp_cnt);
    end
    if (!timed_out) begin
      if (push_full_cnt == 0) begin
        err_cnt++;
        $display("No push was ever made with the entry memory full");
      end
      if (push_reuse_cnt == 0) begin
        err_cnt++;
        $display("No push succeeded after the entry memory had been full");
      end
      if (pop_ok_cnt == 0) begin
        err_cnt++;
        $display("No pop ever returned data");
      end
      if (pop_empty_cnt == 0) begin
        err_cnt++;
        $display("No pop was ever made on an empty stack");
      end
    end
    $display("acks %0d responses %0d full pushes %0d empty pops %0d errors %0d",
             ack_cnt, rsp_cnt, push_full_cnt, pop_empty_cnt, err_cnt);
    if (!timed_out && (err_cnt == 0))
      $display("SIMULATION PASSED");
    else
      $display("SIMULATION FAILED");
    $finish;
  end

endmodule : stk_pipe_tb

// ==== stk_pipe.f ====
common/stk_pkg.sv
stk_pipe/stk_pipe_ad.sv
stk_pipe/stk_pipe_al.sv
stk_pipe/stk_pipe_lk.sv
stk_pipe/stk_pipe_wb.sv
stk_pipe/stk_pipe.sv
verif/stk_pipe_clk_gen.sv
verif/stk_pipe_tb.sv
